/* common/crc_pkg.sv */
`default_nettype none

package crc_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning on the bus and in the core
	//////////////////////////////////////////////////////////////////////

	// Bus word and CRC word
	typedef logic [31:0] word_t;
	// Register index from HADDR[4:2]
	typedef logic [2:0] reg_addr_t;
	// Low bits of HSIZE, 0 byte, 1 halfword, 2 word
	typedef logic [1:0] bus_size_t;
	// Polynomial width code, 0 is 32, 1 is 16, 2 is 8, 3 is 7
	typedef logic [1:0] poly_size_t;
	// Input reversal, 0 none, 1 per byte, 2 per halfword, 3 whole word
	typedef logic [1:0] rev_in_t;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	localparam reg_addr_t CRC_DR   = 3'h0;
	localparam reg_addr_t CRC_IDR  = 3'h1;
	localparam reg_addr_t CRC_CR   = 3'h2;
	localparam reg_addr_t CRC_INIT = 3'h4;
	localparam reg_addr_t CRC_POL  = 3'h5;

	// AHB transfer types
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// AHB-Lite response
	localparam logic RESP_OKAY  = 1'b0;
	localparam logic RESP_ERROR = 1'b1;

	// Reset values, CR fields sit in bits 7:3
	localparam word_t RESET_CR   = 32'h0000_0000;
	localparam word_t RESET_INIT = 32'hFFFF_FFFF;
	localparam word_t RESET_POL  = 32'h04C1_1DB7;

	// Core FSM
	typedef enum logic [0:0]
	{
		CORE_IDLE,
		CORE_SHIFT
	} core_state_t;

endpackage

`default_nettype wire

/* host/host_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module host_interface
(
	input  wire                     HCLK,
	input  wire                     HRESETn,
	input  wire                     HSElx,
	input  wire crc_pkg::word_t     HADDR,
	input  wire logic [1:0]         HTRANS,
	input  wire logic [2:0]         HSIZE,
	input  wire                     HWRITE,
	input  wire                     HREADY,
	input  wire crc_pkg::word_t     HWDATA,
	output crc_pkg::word_t          HRDATA,
	output logic                    HREADYOUT,
	output logic                    HRESP,
	output crc_pkg::word_t          bus_wr,
	output crc_pkg::bus_size_t      bus_size,
	output logic                    buffer_write_en,
	output logic                    crc_init_en,
	output logic                    crc_idr_en,
	output logic                    crc_poly_en,
	output logic                    reset_chain,
	output crc_pkg::poly_size_t     crc_poly_size,
	output crc_pkg::rev_in_t        rev_in_type,
	output logic                    rev_out_type,
	input  wire crc_pkg::word_t     crc_out,
	input  wire crc_pkg::word_t     crc_init_out,
	input  wire crc_pkg::word_t     crc_poly_out,
	input  wire logic [7:0]         crc_idr_out,
	input  wire                     buffer_full,
	input  wire                     reset_pending,
	input  wire                     read_wait
);

	import crc_pkg::*;

	// Address phase held over into the data phase
	reg_addr_t haddr_pp;
	bus_size_t hsize_pp;
	logic [1:0] htrans_pp;
	logic hwrite_pp;
	logic hsel_pp;

	// CR fields {rev_out, rev_in, poly_size}
	logic [4:0] cr_q;

	logic sample_bus;
	logic ahb_enable;
	logic write_en;
	logic read_en;
	logic dr_sel;
	logic idr_sel;
	logic cr_sel;
	logic init_sel;
	logic pol_sel;
	logic dr_wr;
	logic dr_rd;
	logic init_wr;
	logic cr_en;

	//////////////////////////////////////////////////////////////////////
	// Address pipeline
	//////////////////////////////////////////////////////////////////////

	// Transfer qualifiers
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_pp   <= 1'b0;
			htrans_pp <= HTRANS_IDLE;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hsel_pp   <= HSElx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	// Register index and size
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	// Only NONSEQ counts, BUSY and SEQ fall through as no access
	assign ahb_enable = (htrans_pp == HTRANS_NONSEQ);
	assign write_en   = hsel_pp && hwrite_pp && ahb_enable;
	assign read_en    = hsel_pp && !hwrite_pp && ahb_enable;

	assign dr_sel   = (haddr_pp == CRC_DR);
	assign idr_sel  = (haddr_pp == CRC_IDR);
	assign cr_sel   = (haddr_pp == CRC_CR);
	assign init_sel = (haddr_pp == CRC_INIT);
	assign pol_sel  = (haddr_pp == CRC_POL);

	assign dr_wr   = dr_sel && write_en;
	assign dr_rd   = dr_sel && read_en;
	assign init_wr = init_sel && write_en;

	//////////////////////////////////////////////////////////////////////
	// Wait states and strobes
	//////////////////////////////////////////////////////////////////////

	// Stall on a full buffer, a busy CRC or a reload still to come
	assign HREADYOUT = !((dr_wr && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));

	assign sample_bus = HREADYOUT && HREADY;

	// Strobes fire once, in the last cycle of the data phase
	assign buffer_write_en = dr_wr && sample_bus;
	assign crc_init_en     = init_wr && sample_bus;
	assign crc_idr_en      = idr_sel && write_en && sample_bus;
	assign crc_poly_en     = pol_sel && write_en && sample_bus;
	assign cr_en           = cr_sel && write_en && sample_bus;

	// CR bit 0 is self clearing, never stored
	assign reset_chain = cr_en && HWDATA[0];

	// Write data is not pipelined
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;
	assign HRESP    = RESP_OKAY;

	// Control register
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= RESET_CR[7:3];
		else if (cr_en)
			cr_q <= HWDATA[7:3];
	end

	assign crc_poly_size = cr_q[1:0];
	assign rev_in_type   = cr_q[3:2];
	assign rev_out_type  = cr_q[4];

	// Read mux
	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			CRC_CR:   HRDATA = {24'h0, cr_q, 3'b000};
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

endmodule

`default_nettype wire

/* crc_unit/crc_input_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module crc_input_buffer
(
	input  wire                     HCLK,
	input  wire                     HRESETn,
	input  wire                     buffer_write_en,
	input  wire crc_pkg::word_t     bus_wr,
	input  wire crc_pkg::bus_size_t bus_size,
	input  wire crc_pkg::rev_in_t   rev_in_type,
	input  wire                     byte_take,
	output logic                    byte_valid,
	output logic [7:0]              byte_data,
	output logic                    buffer_full
);

	import crc_pkg::*;

	// Left-justified bytes, top byte goes next
	word_t data_q;
	// Bytes still to hand over
	logic [2:0] count_q;
	word_t data_rev;
	word_t data_just;
	logic [2:0] count_new;

	// Bit reversal within bytes, halfwords or the whole word
	function automatic word_t reverse_in(input word_t w, input rev_in_t mode);
		word_t r;
		for (int i = 0; i < 32; i++)
		begin
			case (mode)
				2'd1:    r[i] = w[(i & ~7) + 7 - (i & 7)];
				2'd2:    r[i] = w[(i & ~15) + 15 - (i & 15)];
				2'd3:    r[i] = w[31 - i];
				default: r[i] = w[i];
			endcase
		end
		return r;
	endfunction

	// Reverse first, then move the low bytes of the size to the top
	always_comb
	begin
		data_rev = reverse_in(bus_wr, rev_in_type);
		case (bus_size)
			2'd0:
			begin
				data_just = {data_rev[7:0], 24'h0};
				count_new = 3'd1;
			end
			2'd1:
			begin
				data_just = {data_rev[15:0], 16'h0};
				count_new = 3'd2;
			end
			default:
			begin
				data_just = data_rev;
				count_new = 3'd4;
			end
		endcase
	end

	// Byte counter, the host never writes while bytes remain
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_q <= 3'd0;
		else if (buffer_write_en)
			count_q <= count_new;
		else if (byte_take && count_q != 3'd0)
			count_q <= count_q - 3'd1;
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
			data_q <= data_just;
		else if (byte_take)
			data_q <= data_q << 8;
	end

	assign byte_valid  = (count_q != 3'd0);
	assign buffer_full = (count_q != 3'd0);
	assign byte_data   = data_q[31:24];

endmodule

`default_nettype wire

/* crc_unit/crc_core.sv */
`timescale 1ns/1ps
`default_nettype none

module crc_core
(
	input  wire                     HCLK,
	input  wire                     HRESETn,
	input  wire                     byte_valid,
	input  wire logic [7:0]         byte_data,
	output logic                    byte_take,
	input  wire crc_pkg::word_t     bus_wr,
	input  wire                     crc_init_en,
	input  wire                     crc_poly_en,
	input  wire                     crc_idr_en,
	input  wire                     reset_chain,
	input  wire crc_pkg::poly_size_t crc_poly_size,
	input  wire                     rev_out_type,
	input  wire                     buffer_full,
	output crc_pkg::word_t          crc_out,
	output crc_pkg::word_t          crc_init_out,
	output crc_pkg::word_t          crc_poly_out,
	output logic [7:0]              crc_idr_out,
	output logic                    reset_pending,
	output logic                    read_wait
);

	import crc_pkg::*;

	core_state_t state_q;
	core_state_t state_next;
	word_t crc_q;
	word_t init_q;
	word_t pol_q;
	logic [7:0] idr_q;
	logic reload;
	// Low n bits set for the chosen width
	word_t mask;
	logic [4:0] rev_shift;
	word_t crc_mask;
	word_t crc_flip;

	// All eight bits of one byte, MSB first, no final XOR
	function automatic word_t crc_fold(input word_t crc_in, input logic [7:0] data,
		input word_t poly, input word_t width);
		word_t crc;
		word_t top;
		logic fb;
		crc = crc_in & width;
		// Single bit at position n-1
		top = width ^ (width >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = (|(crc & top)) ^ data[i];
			crc = (crc << 1) & width;
			if (fb)
				crc = crc ^ (poly & width);
		end
		return crc;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Byte FSM
	//////////////////////////////////////////////////////////////////////

	// Idle means the last byte went in a cycle ago or earlier,
	// so any buffered data arrived after the reset request
	assign reload    = reset_pending && (state_q == CORE_IDLE);
	assign byte_take = byte_valid && !reload;

	always_comb
	begin
		case (state_q)
			CORE_IDLE:  state_next = byte_take ? CORE_SHIFT : CORE_IDLE;
			CORE_SHIFT: state_next = byte_take ? CORE_SHIFT : CORE_IDLE;
			default:    state_next = CORE_IDLE;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q       <= CORE_IDLE;
			reset_pending <= 1'b0;
			crc_q         <= RESET_INIT;
			init_q        <= RESET_INIT;
			pol_q         <= RESET_POL;
			idr_q         <= 8'h00;
		end
		else
		begin
			state_q <= state_next;
			// A new request wins over a reload in the same cycle
			if (reset_chain)
				reset_pending <= 1'b1;
			else if (reload)
				reset_pending <= 1'b0;
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				pol_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
			if (reload)
				crc_q <= init_q;
			else if (byte_take)
				crc_q <= crc_fold(crc_q, byte_data, pol_q, mask);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Width and output reversal
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			2'd1:    mask = 32'h0000_FFFF;
			2'd2:    mask = 32'h0000_00FF;
			2'd3:    mask = 32'h0000_007F;
			default: mask = 32'hFFFF_FFFF;
		endcase
		// 32 minus n
		case (crc_poly_size)
			2'd1:    rev_shift = 5'd16;
			2'd2:    rev_shift = 5'd24;
			2'd3:    rev_shift = 5'd25;
			default: rev_shift = 5'd0;
		endcase
		crc_mask = crc_q & mask;
		crc_flip = {<<{crc_mask}};
		crc_out  = rev_out_type ? (crc_flip >> rev_shift) : crc_mask;
	end

	// Reads of DR also hold off until a requested reload is done
	assign read_wait    = buffer_full || (state_q == CORE_SHIFT) || reset_pending;
	assign crc_init_out = init_q;
	assign crc_poly_out = pol_q;
	assign crc_idr_out  = idr_q;

endmodule

`default_nettype wire

/* logic/crc_ahb.sv */
`timescale 1ns/1ps
`default_nettype none

module crc_ahb
(
	input  wire                 HCLK,
	input  wire                 HRESETn,
	input  wire                 HSElx,
	input  wire crc_pkg::word_t HADDR,
	input  wire logic [1:0]     HTRANS,
	input  wire logic [2:0]     HSIZE,
	input  wire                 HWRITE,
	input  wire                 HREADY,
	input  wire crc_pkg::word_t HWDATA,
	output crc_pkg::word_t      HRDATA,
	output logic                HREADYOUT,
	output logic                HRESP
);

	import crc_pkg::*;

	// Host to buffer and core
	word_t bus_wr;
	bus_size_t bus_size;
	logic buffer_write_en;
	logic crc_init_en;
	logic crc_idr_en;
	logic crc_poly_en;
	logic reset_chain;
	poly_size_t crc_poly_size;
	rev_in_t rev_in_type;
	logic rev_out_type;

	// Core back to host
	word_t crc_out;
	word_t crc_init_out;
	word_t crc_poly_out;
	logic [7:0] crc_idr_out;
	logic reset_pending;
	logic read_wait;

	// Buffer and core byte path
	logic buffer_full;
	logic byte_valid;
	logic byte_take;
	logic [7:0] byte_data;

	//////////////////////////////////////////////////////////////////////
	// Bus side
	//////////////////////////////////////////////////////////////////////

	host_interface u_host_interface
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HREADY          (HREADY),
		.HWDATA          (HWDATA),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.reset_chain     (reset_chain),
		.crc_poly_size   (crc_poly_size),
		.rev_in_type     (rev_in_type),
		.rev_out_type    (rev_out_type),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait)
	);

	// Data register staging
	crc_input_buffer u_crc_input_buffer
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.buffer_write_en (buffer_write_en),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.rev_in_type     (rev_in_type),
		.byte_take       (byte_take),
		.byte_valid      (byte_valid),
		.byte_data       (byte_data),
		.buffer_full     (buffer_full)
	);

	// CRC engine and its registers
	crc_core u_crc_core
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.byte_valid    (byte_valid),
		.byte_data     (byte_data),
		.byte_take     (byte_take),
		.bus_wr        (bus_wr),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.crc_idr_en    (crc_idr_en),
		.reset_chain   (reset_chain),
		.crc_poly_size (crc_poly_size),
		.rev_out_type  (rev_out_type),
		.buffer_full   (buffer_full),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out),
		.reset_pending (reset_pending),
		.read_wait     (read_wait)
	);

endmodule

`default_nettype wire

/* tb/crc_ahb_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_chk
(
	input wire                     HCLK,
	input wire                     HRESETn,
	input wire                     HREADYOUT,
	input wire                     HRESP,
	input wire                     hsel_pp,
	input wire logic [1:0]         htrans_pp,
	input wire                     hwrite_pp,
	input wire crc_pkg::reg_addr_t haddr_pp,
	input wire                     buffer_full,
	input wire                     read_wait,
	input wire                     reset_pending,
	input wire                     buffer_write_en,
	input wire                     crc_init_en,
	input wire                     crc_idr_en,
	input wire                     crc_poly_en,
	input wire                     reset_chain
);

	import crc_pkg::*;

	logic stall;
	logic nonseq_pending;
	logic any_strobe;

	assign nonseq_pending = hsel_pp && (htrans_pp == HTRANS_NONSEQ);

	// The three wait-state sources, decoded from the held address phase
	assign stall = nonseq_pending &&
	               ((hwrite_pp && (haddr_pp == CRC_DR) && buffer_full) ||
	                (!hwrite_pp && (haddr_pp == CRC_DR) && read_wait) ||
	                (hwrite_pp && (haddr_pp == CRC_INIT) && reset_pending));
	assign any_strobe = buffer_write_en || crc_init_en || crc_idr_en ||
	                    crc_poly_en || reset_chain;

	stall_drops_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
		stall |-> !HREADYOUT)
		else $error("HREADYOUT high while a stall condition holds");

	// No transfer in its data phase, nothing to wait for
	idle_keeps_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!nonseq_pending |-> HREADYOUT)
		else $error("HREADYOUT low without a pending NONSEQ transfer");

	strobe_needs_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
		any_strobe |-> (nonseq_pending && hwrite_pp))
		else $error("Write strobe without a pipelined write");

	resp_always_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
		HRESP == RESP_OKAY)
		else $error("HRESP is not OKAY");

endmodule

bind host_interface crc_ahb_chk u_crc_ahb_chk
(
	.HCLK            (HCLK),
	.HRESETn         (HRESETn),
	.HREADYOUT       (HREADYOUT),
	.HRESP           (HRESP),
	.hsel_pp         (hsel_pp),
	.htrans_pp       (htrans_pp),
	.hwrite_pp       (hwrite_pp),
	.haddr_pp        (haddr_pp),
	.buffer_full     (buffer_full),
	.read_wait       (read_wait),
	.reset_pending   (reset_pending),
	.buffer_write_en (buffer_write_en),
	.crc_init_en     (crc_init_en),
	.crc_idr_en      (crc_idr_en),
	.crc_poly_en     (crc_poly_en),
	.reset_chain     (reset_chain)
);

`default_nettype wire

/* tb/crc_ahb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_tb;

	import crc_pkg::*;

	// Record layout in the pattern file, five words each
	localparam int FIELDS = 5;
	localparam int MAX_RECORDS = 96;
	// Longest stall seen by one transfer is a few cycles
	localparam int WAIT_LIMIT = 64;

	logic HCLK;
	logic HRESETn;
	logic hsel;
	word_t haddr;
	logic [1:0] htrans;
	logic [2:0] hsize;
	logic hwrite;
	logic hready;
	word_t hwdata;
	word_t hrdata;
	logic hreadyout;
	logic hresp;

	word_t pattern_mem [0:MAX_RECORDS*FIELDS-1];
	integer seed;
	int num_checks;

	// Read whose data phase is still open
	logic pend_read;
	word_t pend_exp;
	word_t pend_addr;

	// Single slave, so the ready output feeds straight back
	assign hready = hreadyout;

	crc_ahb u_crc_ahb
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (hsel),
		.HADDR     (haddr),
		.HTRANS    (htrans),
		.HSIZE     (hsize),
		.HWRITE    (hwrite),
		.HREADY    (hready),
		.HWDATA    (hwdata),
		.HRDATA    (hrdata),
		.HREADYOUT (hreadyout),
		.HRESP     (hresp)
	);

	// 100 ns period
	initial
	begin
		HCLK = 1'b0;
		forever #50 HCLK = ~HCLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	// One address phase, held until accepted, which also closes the
	// data phase before it
	task automatic bus_cycle(input logic active, input logic wr, input word_t addr,
		input logic [2:0] size, input word_t data, input word_t exp);
		logic ready;
		logic resp;
		word_t rdata;
		int waited;
		ready  = 1'b0;
		resp   = 1'b0;
		rdata  = '0;
		waited = 0;
		hsel   <= active;
		htrans <= active ? HTRANS_NONSEQ : HTRANS_IDLE;
		hwrite <= wr;
		haddr  <= addr;
		hsize  <= size;
		// Sample mid-cycle, the edge after it ends the data phase
		while (!ready)
		begin
			@(negedge HCLK);
			ready = hreadyout;
			resp  = hresp;
			rdata = hrdata;
			@(posedge HCLK);
			waited++;
			if (!ready && waited >= WAIT_LIMIT)
				stop_on_error("Timeout, HREADYOUT stayed low too long");
		end
		// Every data phase ends with an OKAY response
		assert (resp == RESP_OKAY)
		else
			stop_on_error($sformatf("Fail HRESP expected %h actual %h",
				RESP_OKAY, resp));
		if (pend_read)
		begin
			num_checks++;
			assert (rdata == pend_exp)
			else
				stop_on_error($sformatf("Fail HRDATA at address %h expected %h actual %h",
					pend_addr, pend_exp, rdata));
		end
		pend_read = active && !wr;
		pend_exp  = exp;
		pend_addr = addr;
		// Write data belongs to the data phase that starts here
		if (active && wr)
			hwdata <= data;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
			bus_cycle(1'b0, 1'b0, '0, 3'd0, '0, '0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Pattern run
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int idx;
		int rec;
		int gap;
		logic done;
		seed       = 32'h383b990a;
		num_checks = 0;
		pend_read  = 1'b0;
		pend_exp   = '0;
		pend_addr  = '0;
		for (int i = 0; i < MAX_RECORDS * FIELDS; i++)
			pattern_mem[i] = '0;
		$readmemh("tb/crc_patterns.hex", pattern_mem);

		HRESETn <= 1'b0;
		hsel    <= 1'b0;
		haddr   <= '0;
		htrans  <= HTRANS_IDLE;
		hsize   <= 3'd0;
		hwrite  <= 1'b0;
		hwdata  <= '0;
		repeat (5) @(posedge HCLK);
		HRESETn <= 1'b1;
		@(posedge HCLK);

		// Op 1 write, 2 read and compare, 3 idle, anything else ends
		idx  = 0;
		done = 1'b0;
		while (!done && idx < MAX_RECORDS)
		begin
			rec = idx * FIELDS;
			case (pattern_mem[rec])
				32'd1, 32'd2:
				begin
					bus_cycle(1'b1, pattern_mem[rec] == 32'd1, pattern_mem[rec+1],
						pattern_mem[rec+2][2:0], pattern_mem[rec+3], pattern_mem[rec+4]);
					gap = $random(seed) & 3;
					idle_cycles(gap);
				end
				32'd3:
					idle_cycles(pattern_mem[rec+3]);
				default:
					done = 1'b1;
			endcase
			idx++;
		end
		// Closes the last data phase and its read check
		idle_cycles(1);

		if (num_checks > 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
			stop_on_error("No read was checked, the pattern file looks empty");
	end

endmodule

`default_nettype wire

/* tb/crc_patterns.hex */
// op addr size data expected, op 1 write, 2 read and compare, 3 idle (count in data)
// addr is the byte address, size is HSIZE, op 0 ends the run
2 14 2 00000000 04C11DB7
2 10 2 00000000 FFFFFFFF
2 08 2 00000000 00000000
2 04 2 00000000 00000000
2 00 2 00000000 FFFFFFFF
1 04 2 12345678 00000000
2 04 2 00000000 00000078
// Chain reset, word 0, then back-to-back words
1 08 2 00000001 00000000
1 00 2 00000000 00000000
2 00 2 00000000 C704DD7B
1 00 2 C704DD7B 00000000
1 00 2 00000001 00000000
2 00 2 00000000 04C11DB7
1 00 2 04C11DB7 00000000
1 00 2 00000002 00000000
2 00 2 00000000 09823B6E
// Mixed byte, halfword and word
1 08 2 00000001 00000000
1 00 2 FFFFFFFF 00000000
1 00 2 00000001 00000000
1 00 0 00000004 00000000
2 00 2 00000000 C11DB700
1 00 1 0000C11D 00000000
2 00 2 00000000 B7000000
1 00 0 000000B6 00000000
2 00 2 00000000 04C11DB7
1 00 0 00000005 00000000
2 00 2 00000000 C5DCAAB7
// 16-bit polynomial
1 14 2 00001021 00000000
1 10 2 0000ABCD 00000000
1 08 2 00000009 00000000
2 08 2 00000000 00000008
2 14 2 00000000 00001021
2 00 2 00000000 0000ABCD
1 00 1 0000ABCD 00000000
1 00 1 00000001 00000000
2 00 2 00000000 00001021
1 00 0 00000010 00000000
2 00 2 00000000 00002100
1 00 2 21000000 00000000
1 00 2 00000001 00000000
2 00 2 00000000 00001021
// 8-bit polynomial, then output reversal within 8 bits
1 14 2 00000007 00000000
1 10 2 0000005A 00000000
1 08 2 00000011 00000000
2 08 2 00000000 00000010
1 00 0 0000005A 00000000
1 00 0 00000001 00000000
2 00 2 00000000 00000007
1 00 0 00000000 00000000
2 00 2 00000000 00000015
1 08 2 00000090 00000000
2 00 2 00000000 000000A8
// Input reversal modes and 32-bit output reversal
1 14 2 04C11DB7 00000000
1 10 2 00000000 00000000
1 08 2 00000021 00000000
2 08 2 00000000 00000020
1 00 2 00000080 00000000
2 00 2 00000000 04C11DB7
1 08 2 00000041 00000000
2 08 2 00000000 00000040
1 00 1 00008000 00000000
2 00 2 00000000 04C11DB7
1 08 2 00000061 00000000
1 00 2 80000000 00000000
2 00 2 00000000 04C11DB7
1 08 2 000000E1 00000000
2 08 2 00000000 000000E0
1 00 2 80000000 00000000
2 00 2 00000000 EDB88320
// Chain reset in the middle of a sequence
1 10 2 FFFFFFFF 00000000
1 08 2 00000001 00000000
1 00 2 12345678 00000000
1 00 1 0000ABCD 00000000
1 08 2 00000001 00000000
1 10 2 00000000 00000000
2 00 2 00000000 FFFFFFFF
2 10 2 00000000 00000000
3 00 0 00000003 00000000
1 00 2 00000000 00000000
2 00 2 00000000 C704DD7B
0 00 0 00000000 00000000

/* crc_ahb.f */
common/crc_pkg.sv
host/host_interface.sv
crc_unit/crc_input_buffer.sv
crc_unit/crc_core.sv
logic/crc_ahb.sv
tb/crc_ahb_chk.sv
tb/crc_ahb_tb.sv

/* Makefile */
TOP = crc_ahb_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f crc_ahb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
